// File: design/uart_echo_pkg.sv
package uart_echo_pkg;

    typedef logic [7:0] byte_t;  // one serial data byte

    // fourth encoding is unused, handled as echo
    typedef enum logic [1:0] {
        MODE_ECHO  = 2'd0,
        MODE_UPPER = 2'd1,
        MODE_SWAP  = 2'd2
    } echo_mode_t;

    // echo -> upper -> swap -> echo
    function automatic echo_mode_t next_mode(input echo_mode_t mode);
        case (mode)
            MODE_ECHO:  return MODE_UPPER;
            MODE_UPPER: return MODE_SWAP;
            default:    return MODE_ECHO;  // swap and the spare code wrap
        endcase
    endfunction

    function automatic byte_t transform_byte(input byte_t data, input echo_mode_t mode);
        logic is_lower;
        logic is_upper;
        is_lower = (data >= 8'h61) && (data <= 8'h7a);  // 'a'..'z'
        is_upper = (data >= 8'h41) && (data <= 8'h5a);  // 'A'..'Z'
        case (mode)
            MODE_UPPER: return is_lower ? (data ^ 8'h20) : data;
            MODE_SWAP:  return (is_lower || is_upper) ? (data ^ 8'h20) : data;
            default:    return data;  // plain echo
        endcase
    endfunction

endpackage

// File: design/uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
    parameter int CLKS_PER_BAUD = 104
) (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_rx,
    output logic                 o_wr,    // one-cycle strobe at mid stop bit
    output uart_echo_pkg::byte_t o_data
);
    import uart_echo_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BAUD);

    logic [1:0]       rx_sync;   // [1] is the synced line
    logic             busy;      // frame in progress
    logic [CNT_W-1:0] baud_cnt;  // cycles left to next sample point
    logic [3:0]       bit_idx;   // 0 start, 1..8 data, 9 stop
    byte_t            shift;

    assign o_data = shift;

    always_ff @(posedge clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            rx_sync  <= 2'b11;  // line idles high
            busy     <= 1'b0;
            baud_cnt <= '0;
            bit_idx  <= '0;
            o_wr     <= 1'b0;
        end
        else
        begin
            rx_sync <= {rx_sync[0], i_rx};
            o_wr    <= 1'b0;
            if (!busy)
            begin
                if (!rx_sync[1])  // start edge seen
                begin
                    busy     <= 1'b1;
                    baud_cnt <= CNT_W'(CLKS_PER_BAUD / 2 - 1);  // aim at mid start bit
                    bit_idx  <= '0;
                end
            end
            else if (baud_cnt != '0)
                baud_cnt <= baud_cnt - 1'b1;
            else
            begin
                baud_cnt <= CNT_W'(CLKS_PER_BAUD - 1);
                bit_idx  <= bit_idx + 1'b1;
                if (bit_idx == 4'd0 && rx_sync[1])
                    busy <= 1'b0;  // start bit gone high means a glitch
                else if (bit_idx == 4'd9)
                begin
                    busy <= 1'b0;
                    o_wr <= rx_sync[1];  // framing error drops the byte
                end
            end
        end
    end

    // data bits shift in lsb first
    always_ff @(posedge clk)
    begin
        if (busy && baud_cnt == '0 && bit_idx != 4'd0 && bit_idx <= 4'd8)
            shift <= {rx_sync[1], shift[7:1]};
    end

    // a strobe ends a frame begun at least nine bit times earlier
    assert property (@(posedge clk) disable iff (!i_rst_n)
                     o_wr |-> $past(busy, 9 * CLKS_PER_BAUD))
        else $error("uart_rx: write strobe without a full frame");

endmodule

// File: design/uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
    parameter int CLKS_PER_BAUD = 104
) (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_wr,
    input  uart_echo_pkg::byte_t i_data,
    output logic                 o_tx,
    output logic                 o_busy
);

    localparam int CNT_W = $clog2(CLKS_PER_BAUD);

    logic [9:0]       frame;      // stop, data msb..lsb, start
    logic [CNT_W-1:0] baud_cnt;
    logic [3:0]       bits_left;  // shifts still to do

    assign o_tx = frame[0];  // frame refills with ones, so idle is high

    always_ff @(posedge clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            frame     <= '1;
            baud_cnt  <= '0;
            bits_left <= '0;
            o_busy    <= 1'b0;
        end
        else if (!o_busy)
        begin
            if (i_wr)
            begin
                frame     <= {1'b1, i_data, 1'b0};
                baud_cnt  <= CNT_W'(CLKS_PER_BAUD - 1);
                bits_left <= 4'd9;
                o_busy    <= 1'b1;
            end
        end
        else if (baud_cnt != '0)
            baud_cnt <= baud_cnt - 1'b1;
        else if (bits_left == 4'd0)
            o_busy <= 1'b0;  // stop bit done
        else
        begin
            frame     <= {1'b1, frame[9:1]};  // next bit, lsb first
            bits_left <= bits_left - 1'b1;
            baud_cnt  <= CNT_W'(CLKS_PER_BAUD - 1);
        end
    end

    // the outbox controller must wait for idle, else the byte is lost
    assert property (@(posedge clk) disable iff (!i_rst_n) o_busy |-> !i_wr)
        else $error("uart_tx: write while busy");

endmodule

// File: design/byte_fifo.sv
`timescale 1ns/1ps

module byte_fifo #(
    parameter int FIFO_DEPTH = 16  // power of two
) (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_clear,  // sync flush
    input  logic                 i_wr,
    input  logic                 i_rd,
    input  uart_echo_pkg::byte_t i_data,
    output uart_echo_pkg::byte_t o_data,   // head, valid while not empty
    output logic                 o_empty,
    output logic                 o_full
);
    import uart_echo_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    byte_t       mem [FIFO_DEPTH];
    logic [AW:0] wr_ptr;  // msb is the wrap bit
    logic [AW:0] rd_ptr;
    logic        do_wr;
    logic        do_rd;

    assign o_empty = (wr_ptr == rd_ptr);
    assign o_full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign o_data  = mem[rd_ptr[AW-1:0]];  // fall-through head

    assign do_rd = i_rd && !o_empty;
    assign do_wr = i_wr && (!o_full || do_rd);  // full + read frees a slot

    always_ff @(posedge clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else if (i_clear)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_wr)
            mem[wr_ptr[AW-1:0]] <= i_data;
    end

    // consumers check the flags a cycle ahead
    assert property (@(posedge clk) disable iff (!i_rst_n) i_rd |-> !o_empty)
        else $error("byte_fifo: read while empty");
    assert property (@(posedge clk) disable iff (!i_rst_n) (i_wr && o_full) |-> i_rd)
        else $error("byte_fifo: write while full, byte dropped");

endmodule

// File: design/key_debouncer.sv
`timescale 1ns/1ps

module key_debouncer #(
    parameter int DEBOUNCE_CYCLES = 50000
) (
    input  logic clk,
    input  logic i_rst_n,
    input  logic i_btn,    // raw board button
    output logic o_press,  // one pulse per accepted rise
    output logic o_state   // debounced level
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    logic [1:0]       btn_sync;  // [1] is synced
    logic [CNT_W-1:0] stable_cnt;

    always_ff @(posedge clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            btn_sync   <= 2'b00;
            stable_cnt <= '0;
            o_state    <= 1'b0;
            o_press    <= 1'b0;
        end
        else
        begin
            btn_sync <= {btn_sync[0], i_btn};
            o_press  <= 1'b0;
            if (btn_sync[1] == o_state)
                stable_cnt <= '0;  // no change pending, or glitch over
            else if (stable_cnt == CNT_W'(DEBOUNCE_CYCLES - 1))
            begin
                stable_cnt <= '0;
                o_state    <= btn_sync[1];
                o_press    <= btn_sync[1];  // rises only
            end
            else
                stable_cnt <= stable_cnt + 1'b1;
        end
    end

endmodule

// File: design/mode_regs.sv
`timescale 1ns/1ps

module mode_regs (
    input  logic                      clk,
    input  logic                      i_rst_n,
    input  logic                      i_clear,  // sw1, back to echo and 0
    input  logic                      i_step,   // sw2, next mode
    input  logic                      i_taken,  // one byte processed
    output uart_echo_pkg::echo_mode_t o_mode,
    output logic [5:0]                o_count   // wraps at 64
);
    import uart_echo_pkg::*;

    always_ff @(posedge clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_mode  <= MODE_ECHO;
            o_count <= '0;
        end
        else if (i_clear)  // clear wins over step and count
        begin
            o_mode  <= MODE_ECHO;
            o_count <= '0;
        end
        else
        begin
            if (i_step)
                o_mode <= next_mode(o_mode);
            if (i_taken)
                o_count <= o_count + 1'b1;
        end
    end

endmodule

// File: design/echo_core.sv
`timescale 1ns/1ps

module echo_core (
    input  logic                      clk,
    input  logic                      i_rst_n,
    input  logic                      i_clear,
    input  logic                      i_empty,  // inbox empty
    input  logic                      i_full,   // outbox full
    input  uart_echo_pkg::byte_t      i_data,   // inbox head
    input  uart_echo_pkg::echo_mode_t i_mode,
    output logic                      o_rd,     // pop inbox
    output logic                      o_wr,     // push outbox
    output logic                      o_taken,  // count strobe
    output uart_echo_pkg::byte_t      o_data
);
    import uart_echo_pkg::*;

    logic xfer;  // registered move decision
    logic go;

    // skip the cycle after a move, flags update one edge late
    assign go = !i_empty && !i_full && !xfer;

    assign o_rd    = xfer;
    assign o_wr    = xfer;
    assign o_taken = xfer;

    always_ff @(posedge clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            xfer <= 1'b0;
        else
            xfer <= go && !i_clear;  // flush drops the pending move
    end

    // head stays put until popped, so this matches the popped byte
    always_ff @(posedge clk)
    begin
        if (go)
            o_data <= transform_byte(i_data, i_mode);
    end

endmodule

// File: design/outbox_tx_ctl.sv
`timescale 1ns/1ps

module outbox_tx_ctl (
    input  logic clk,
    input  logic i_rst_n,
    input  logic i_empty,  // outbox empty
    input  logic i_busy,   // transmitter busy
    output logic o_pop     // pops outbox and starts tx
);

    always_ff @(posedge clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            o_pop <= 1'b0;
        else
            o_pop <= !i_empty && !i_busy && !o_pop;  // busy rises a cycle after pop
    end

    // empty is only read here, pop decision stays valid for one cycle
    assert property (@(posedge clk) disable iff (!i_rst_n) o_pop |-> !i_empty)
        else $error("outbox_tx_ctl: pop from empty outbox");

endmodule

// File: design/uart_echo_top.sv
`timescale 1ns/1ps

module uart_echo_top #(
    parameter int CLKS_PER_BAUD   = 104,
    parameter int FIFO_DEPTH      = 16,
    parameter int DEBOUNCE_CYCLES = 50000
) (
    input  logic       clk,
    input  logic       i_rst_n,
    input  logic       i_rx,
    input  logic       i_sw1,   // flush and clear status
    input  logic       i_sw2,   // step mode
    output logic       o_tx,
    output logic [7:0] o_leds   // mode on top, count below
);
    import uart_echo_pkg::*;

    logic       rx_wr;
    byte_t      rx_data;
    byte_t      in_head;
    logic       in_empty;
    logic       core_rd;
    logic       core_wr;
    logic       core_taken;
    byte_t      core_data;
    byte_t      out_head;
    logic       out_empty;
    logic       out_full;
    logic       tx_pop;
    logic       tx_busy;
    logic       sw1_press;
    logic       sw2_press;
    echo_mode_t mode;
    logic [5:0] count;

    assign o_leds = {mode, count};

    uart_rx #(.CLKS_PER_BAUD(CLKS_PER_BAUD)) u_rx (
        .clk(clk), .i_rst_n(i_rst_n), .i_rx(i_rx), .o_wr(rx_wr), .o_data(rx_data)
    );

    byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_inbox (
        .clk(clk), .i_rst_n(i_rst_n), .i_clear(sw1_press),
        .i_wr(rx_wr), .i_rd(core_rd), .i_data(rx_data),
        .o_data(in_head), .o_empty(in_empty), .o_full()  // overflow just loses the byte
    );

    echo_core u_core (
        .clk(clk), .i_rst_n(i_rst_n), .i_clear(sw1_press),
        .i_empty(in_empty), .i_full(out_full), .i_data(in_head), .i_mode(mode),
        .o_rd(core_rd), .o_wr(core_wr), .o_taken(core_taken), .o_data(core_data)
    );

    mode_regs u_regs (
        .clk(clk), .i_rst_n(i_rst_n), .i_clear(sw1_press), .i_step(sw2_press),
        .i_taken(core_taken), .o_mode(mode), .o_count(count)
    );

    byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_outbox (
        .clk(clk), .i_rst_n(i_rst_n), .i_clear(sw1_press),
        .i_wr(core_wr), .i_rd(tx_pop), .i_data(core_data),
        .o_data(out_head), .o_empty(out_empty), .o_full(out_full)
    );

    outbox_tx_ctl u_txctl (
        .clk(clk), .i_rst_n(i_rst_n), .i_empty(out_empty), .i_busy(tx_busy), .o_pop(tx_pop)
    );

    // head is still valid in the pop cycle
    uart_tx #(.CLKS_PER_BAUD(CLKS_PER_BAUD)) u_tx (
        .clk(clk), .i_rst_n(i_rst_n), .i_wr(tx_pop), .i_data(out_head),
        .o_tx(o_tx), .o_busy(tx_busy)
    );

    key_debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_db_sw1 (
        .clk(clk), .i_rst_n(i_rst_n), .i_btn(i_sw1), .o_press(sw1_press), .o_state()
    );

    key_debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_db_sw2 (
        .clk(clk), .i_rst_n(i_rst_n), .i_btn(i_sw2), .o_press(sw2_press), .o_state()
    );

endmodule

// File: dv/uart_echo_tb.sv
`timescale 1ns/1ps

module uart_echo_tb;

    localparam int CLKS_PER_BAUD   = 8;
    localparam int FIFO_DEPTH      = 16;
    localparam int DEBOUNCE_CYCLES = 4;
    localparam int FRAME_CYCLES    = 10 * CLKS_PER_BAUD;  // start, 8 data, stop
    localparam int FRAME_NS        = FRAME_CYCLES * 100;
    localparam int HOLD_CYCLES     = DEBOUNCE_CYCLES + 8;  // past sync and debounce
    localparam int MAX_TAB         = 16;
    localparam logic [1:0] M_ECHO  = 2'd0;
    localparam logic [1:0] M_UPPER = 2'd1;
    localparam logic [1:0] M_SWAP  = 2'd2;

    logic       clk;
    logic       i_rst_n;
    logic       i_rx;
    logic       i_sw1;
    logic       i_sw2;
    logic       o_tx;
    logic [7:0] o_leds;

    // one row per test
    string      t_name  [MAX_TAB];
    int         t_steps [MAX_TAB];  // sw2 presses before the byte
    logic       t_clear [MAX_TAB];  // sw1 press before
    logic       t_glitch[MAX_TAB];  // short sw2 pulse before
    int         t_burst [MAX_TAB];  // 0 means one fixed byte
    logic [7:0] t_data  [MAX_TAB];
    logic [7:0] t_exp   [MAX_TAB];
    logic [1:0] t_mode  [MAX_TAB];  // mode expected on leds
    int         n_tab = 0;
    logic       table_done = 1'b0;
    logic [1:0] build_mode = M_ECHO;

    logic [7:0] rx_q[$];   // decoded from o_tx
    logic [7:0] exp_q[$];
    int         errors = 0;
    int         checks = 0;
    integer     seed = 32'h6c11;

    uart_echo_top #(
        .CLKS_PER_BAUD(CLKS_PER_BAUD), .FIFO_DEPTH(FIFO_DEPTH),
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) uut (
        .clk(clk), .i_rst_n(i_rst_n), .i_rx(i_rx), .i_sw1(i_sw1), .i_sw2(i_sw2),
        .o_tx(o_tx), .o_leds(o_leds)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // only letters change case
    function automatic logic [7:0] case_rule(input logic [7:0] c, input logic [1:0] m);
        logic lower;
        logic upper;
        lower = (c >= 8'h61) && (c <= 8'h7a);
        upper = (c >= 8'h41) && (c <= 8'h5a);
        if ((m == M_UPPER || m == M_SWAP) && lower)
            return c - 8'h20;
        if (m == M_SWAP && upper)
            return c + 8'h20;
        return c;
    endfunction

    task automatic add_entry(input string name, input int steps, input logic clr,
                             input logic glitch, input int burst, input logic [7:0] data);
        if (clr)
            build_mode = M_ECHO;
        repeat (steps)
            build_mode = (build_mode == M_SWAP) ? M_ECHO : build_mode + 2'd1;
        t_name[n_tab]   = name;
        t_steps[n_tab]  = steps;
        t_clear[n_tab]  = clr;
        t_glitch[n_tab] = glitch;
        t_burst[n_tab]  = burst;
        t_data[n_tab]   = data;
        t_exp[n_tab]    = case_rule(data, build_mode);
        t_mode[n_tab]   = build_mode;
        n_tab++;
    endtask

    task automatic check(input logic [7:0] got, input logic [7:0] exp, input string what);
        checks++;
        if (got !== exp)
        begin
            $display("ERROR %0d ns: %s, got 8'h%02h expected 8'h%02h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #1;  // inputs move just after the edge
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};  // lsb goes first
        for (int k = 0; k < 10; k++)
        begin
            i_rx = frame[k];
            wait_cycles(CLKS_PER_BAUD);
        end
    endtask

    task automatic press_button(input logic sw2);
        if (sw2)
            i_sw2 = 1'b1;
        else
            i_sw1 = 1'b1;
        wait_cycles(HOLD_CYCLES);
        i_sw1 = 1'b0;
        i_sw2 = 1'b0;
        wait_cycles(HOLD_CYCLES);  // release settles too
    endtask

    task automatic glitch_sw2();
        i_sw2 = 1'b1;
        wait_cycles(DEBOUNCE_CYCLES - 2);  // too short to be accepted
        i_sw2 = 1'b0;
        wait_cycles(HOLD_CYCLES);
    endtask

    task automatic wait_echo(input int n);
        int waited;
        waited = 0;
        while (rx_q.size() < n && waited < (n + 4) * FRAME_CYCLES)
        begin
            wait_cycles(1);
            waited++;
        end
        if (rx_q.size() < n)
        begin
            $display("echo timeout at %0d ns: %0d of %0d bytes came back",
                     $time, rx_q.size(), n);
            errors++;
        end
    endtask

    // serial monitor samples o_tx mid bit on the falling clock
    initial
    begin
        logic [7:0] b;
        forever
        begin
            @(negedge clk);
            if (i_rst_n && o_tx == 1'b0)
            begin
                repeat (CLKS_PER_BAUD / 2) @(negedge clk);
                for (int k = 0; k < 8; k++)
                begin
                    repeat (CLKS_PER_BAUD) @(negedge clk);
                    b[k] = o_tx;
                end
                repeat (CLKS_PER_BAUD) @(negedge clk);
                if (o_tx !== 1'b1)
                begin
                    $display("framing broken on o_tx at %0d ns, stop bit was low", $time);
                    errors++;
                end
                else
                    rx_q.push_back(b);
            end
        end
    end

    // watchdog allows about 12 frames per row
    initial
    begin
        wait (table_done);
        #((n_tab * 12 + 20) * FRAME_NS);
        $display("watchdog expired, the run did not finish in time");
        $display("Something failed");
        $finish;
    end

    initial
    begin
        logic [7:0] b;
        int         n;
        int         count_model;
        int         errs_before;
        i_rst_n     = 1'b0;
        i_rx        = 1'b1;  // idle line
        i_sw1       = 1'b0;
        i_sw2       = 1'b0;
        count_model = 0;
        add_entry("echo H", 0, 1'b0, 1'b0, 0, 8'h48);
        add_entry("echo 0", 0, 1'b0, 1'b0, 0, 8'h30);
        add_entry("upper a", 1, 1'b0, 1'b0, 0, 8'h61);
        add_entry("upper Q", 0, 1'b0, 1'b0, 0, 8'h51);
        add_entry("upper !", 0, 1'b0, 1'b0, 0, 8'h21);
        add_entry("upper 7", 0, 1'b0, 1'b0, 0, 8'h37);
        add_entry("swap m", 1, 1'b0, 1'b0, 0, 8'h6d);
        add_entry("swap K", 0, 1'b0, 1'b0, 0, 8'h4b);
        add_entry("swap @", 0, 1'b0, 1'b0, 0, 8'h40);  // just below A
        add_entry("glitch x", 0, 1'b0, 1'b1, 0, 8'h78);
        add_entry("swap burst", 0, 1'b0, 1'b0, 12, 8'h00);
        add_entry("echo b", 1, 1'b0, 1'b0, 0, 8'h62);
        add_entry("upper burst", 1, 1'b0, 1'b0, FIFO_DEPTH, 8'h00);
        add_entry("clear c", 0, 1'b1, 1'b0, 0, 8'h63);
        table_done = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        i_rst_n = 1'b1;
        wait_cycles(2);
        check({7'b0, o_tx}, 8'h01, "o_tx idle after reset");
        check(o_leds, 8'h00, "o_leds after reset");
        $display("test 0 reset state %s", (errors == 0) ? "passed" : "FAILED");
        for (int i = 0; i < n_tab; i++)
        begin
            errs_before = errors;
            if (rx_q.size() != 0)
            begin
                $display("stray bytes on o_tx before test %0d", i + 1);
                errors++;
                rx_q.delete();
            end
            if (t_clear[i])
            begin
                press_button(1'b0);
                count_model = 0;
                check(o_leds, 8'h00, "o_leds after clear");
            end
            if (t_glitch[i])
                glitch_sw2();
            repeat (t_steps[i]) press_button(1'b1);
            check({6'b0, o_leds[7:6]}, {6'b0, t_mode[i]}, "mode on leds");
            n = (t_burst[i] == 0) ? 1 : t_burst[i];
            exp_q.delete();
            for (int k = 0; k < n; k++)
            begin
                b = (t_burst[i] == 0) ? t_data[i] : 8'($random(seed));
                exp_q.push_back((t_burst[i] == 0) ? t_exp[i] : case_rule(b, t_mode[i]));
                send_byte(b);  // back to back within a burst
            end
            wait_echo(n);
            while (rx_q.size() > 0 && exp_q.size() > 0)
                check(rx_q.pop_front(), exp_q.pop_front(), "echoed byte");
            count_model += n;
            check(o_leds, {t_mode[i], 6'(count_model)}, "mode and count on leds");
            $display("test %0d %s %s", i + 1, t_name[i],
                     (errors == errs_before) ? "passed" : "FAILED");
        end
        $display("%0d tests, %0d checks, %0d errors", n_tab + 1, checks, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// File: files.f
design/uart_echo_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/byte_fifo.sv
design/key_debouncer.sv
design/mode_regs.sv
design/echo_core.sv
design/outbox_tx_ctl.sv
design/uart_echo_top.sv
dv/uart_echo_tb.sv

// File: Makefile
TOP := uart_echo_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -o sim
	./obj_dir/sim > sim.log 2>&1; cat sim.log
	@grep -q "Everything OK" sim.log || (echo "simulation FAILED"; exit 1)

clean:
	rm -rf obj_dir sim.log
